// File: Bender.yml
package:
  name: pcie_top

sources:
  - pcie_rb_pkg.sv
  - frb_buffer.sv
  - pio_regs.sv
  - ring_sched.sv
  - f2c_ring.sv
  - pcie_top.sv
  - target: test
    files:
      - tb_pcie_top.sv

// File: f2c_ring.sv
`timescale 1ns/1ps

module f2c_ring
    import pcie_rb_pkg::*;
#(
    parameter int RB_AWIDTH = 16,
    parameter int MAX_PDU_FLITS = 8,
    parameter int PEND_DEPTH = 4,
    localparam int BUF_AW = $clog2(PEND_DEPTH * MAX_PDU_FLITS),
    localparam int SIZE_W = $clog2(MAX_PDU_FLITS + 1)
) (
    input  logic                 pcie_clk,
    input  logic                 pcie_reset_n,
    input  ctrl_reg_t            ctrl,
    input  ring_sel_t            sel,
    input  logic                 update_valid,
    input  logic [SIZE_W-1:0]    update_size,
    output logic [BUF_AW-1:0]    base_addr,
    output logic                 base_addr_valid,
    output logic                 almost_full,
    output logic                 wrdm_desc_valid,
    output wrdm_desc_t           wrdm_desc_data,
    input  logic                 wrdm_desc_ready,
    output logic                 dma_done,
    output logic [RB_AWIDTH-1:0] new_tail
);

    localparam int SLOT_W = (PEND_DEPTH > 1) ? $clog2(PEND_DEPTH) : 1;
    localparam int CNT_W = $clog2(PEND_DEPTH + 1);

    // commit queue; the write pointer doubles as the open slot
    logic [BUF_AW-1:0] q_base [PEND_DEPTH];
    logic [SIZE_W-1:0] q_size [PEND_DEPTH];
    logic [SLOT_W-1:0] slot_idx;
    logic [SLOT_W-1:0] rd_ptr;
    logic [CNT_W-1:0]  q_count;
    logic              settle;
    logic [7:0]        desc_id;
    logic              accept;
    logic              can_issue;
    logic [31:0]       rb_size_w;
    logic [31:0]       free_space;
    logic [31:0]       tail_sum;
    logic [31:0]       next_tail;

    assign base_addr       = BUF_AW'(32'(slot_idx) * MAX_PDU_FLITS);
    assign base_addr_valid = (q_count != CNT_W'(PEND_DEPTH)) && !ctrl.disabled;
    assign almost_full     = q_count >= CNT_W'(PEND_DEPTH - 1);

    assign accept   = wrdm_desc_valid & wrdm_desc_ready;
    assign dma_done = accept;

    // free space and next tail of the selected ring
    assign rb_size_w  = 32'(ctrl.rb_size);
    assign free_space = (sel.head > sel.tail) ? sel.head - sel.tail - 32'd1
                                              : sel.head + rb_size_w - sel.tail - 32'd1;
    assign tail_sum   = sel.tail + 32'(q_size[rd_ptr]);
    assign next_tail  = (tail_sum >= rb_size_w) ? tail_sum - rb_size_w : tail_sum;

    assign can_issue = !wrdm_desc_valid && !settle && (q_count != '0) && !ctrl.disabled &&
                       (32'(q_size[rd_ptr]) <= free_space);

    always_ff @(posedge pcie_clk) begin
        if (!pcie_reset_n) begin
            slot_idx        <= '0;
            rd_ptr          <= '0;
            q_count         <= '0;
            settle          <= 1'b0;
            desc_id         <= '0;
            wrdm_desc_valid <= 1'b0;
        end else begin
            if (update_valid) begin
                slot_idx <= (32'(slot_idx) == PEND_DEPTH - 1) ? '0 : slot_idx + 1'b1;
            end
            if (accept) begin
                rd_ptr <= (32'(rd_ptr) == PEND_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            end
            case ({update_valid, accept})
                2'b10: q_count <= q_count + 1'b1;
                2'b01: q_count <= q_count - 1'b1;
                default: q_count <= q_count;
            endcase
            // scheduler needs a cycle to present the next core
            settle <= accept;
            if (accept) begin
                wrdm_desc_valid <= 1'b0;
            end else if (can_issue) begin
                wrdm_desc_valid <= 1'b1;
                desc_id         <= desc_id + 8'd1;
            end
        end
    end

    always_ff @(posedge pcie_clk) begin
        if (update_valid) begin
            q_base[slot_idx] <= base_addr;
            q_size[slot_idx] <= update_size;
        end
        if (can_issue) begin
            wrdm_desc_data.dst_addr <= sel.kmem_addr + (64'(sel.tail) << FLIT_BYTE_BITS);
            wrdm_desc_data.src_addr <= 64'(q_base[rd_ptr]) << FLIT_BYTE_BITS;
            wrdm_desc_data.desc_id  <= desc_id;
            wrdm_desc_data.dw_count <= 18'(32'(q_size[rd_ptr]) * DW_PER_FLIT);
            wrdm_desc_data.rsvd     <= '0;
            new_tail                <= next_tail[RB_AWIDTH-1:0];
        end
    end

    a_desc_stable: assert property (@(posedge pcie_clk) disable iff (!pcie_reset_n)
        wrdm_desc_valid && !wrdm_desc_ready |=> wrdm_desc_valid && $stable(wrdm_desc_data));

    a_no_commit_when_full: assert property (@(posedge pcie_clk) disable iff (!pcie_reset_n)
        update_valid |-> q_count < CNT_W'(PEND_DEPTH));

    a_tail_in_ring: assert property (@(posedge pcie_clk) disable iff (!pcie_reset_n)
        dma_done |-> 32'(new_tail) < rb_size_w);

endmodule

// File: frb_buffer.sv
`timescale 1ns/1ps

module frb_buffer
    import pcie_rb_pkg::*;
#(
    parameter int MAX_PDU_FLITS = 8,
    parameter int PEND_DEPTH = 4,
    localparam int DEPTH = PEND_DEPTH * MAX_PDU_FLITS,
    localparam int BUF_AW = $clog2(DEPTH)
) (
    input  logic              pcie_clk,
    input  logic              pcie_reset_n,
    input  logic              wr_en,
    input  logic [BUF_AW-1:0] wr_line,
    input  flit_t             wr_data,
    input  logic              rd_en,
    input  logic [BUF_AW-1:0] rd_line,
    output flit_t             rd_data
);

    flit_t             mem [DEPTH];
    logic [BUF_AW-1:0] rd_line_q;

    always_ff @(posedge pcie_clk) begin
        if (wr_en) begin
            mem[wr_line] <= wr_data;
        end
    end

    // address register then output register, two cycles to data
    always_ff @(posedge pcie_clk) begin
        if (rd_en) begin
            rd_line_q <= rd_line;
        end
        rd_data <= mem[rd_line_q];
    end

    // the packet engine must stay inside the staging area
    a_wr_line_range: assert property (@(posedge pcie_clk) disable iff (!pcie_reset_n)
        wr_en |-> 32'(wr_line) < DEPTH);

endmodule

// File: pcie_rb_pkg.sv
package pcie_rb_pkg;

    // one pdu flit, 16 dwords
    typedef logic [511:0] flit_t;

    // write-dma descriptor as the dma engine expects it
    typedef struct packed {
        logic [63:0] dst_addr;
        logic [63:0] src_addr;
        logic [7:0]  desc_id;
        logic [17:0] dw_count;
        logic [19:0] rsvd;
    } wrdm_desc_t;

    // control page, word 0
    typedef struct packed {
        logic [4:0]  total_core;
        logic [25:0] rb_size;
        logic        disabled;
    } ctrl_reg_t;

    // pointers are zero-extended to a full register word
    typedef struct packed {
        logic [31:0] head;
        logic [31:0] tail;
        logic [63:0] kmem_addr;
    } ring_sel_t;

    // page index starts at this bit of a bar 0 address
    localparam int PAGE_BITS = 12;
    localparam int REGS_PER_PAGE = 4;

    // byte offset bits inside one flit
    localparam int FLIT_BYTE_BITS = 6;
    localparam int DW_PER_FLIT = 16;

endpackage

// File: pcie_top.f
pcie_rb_pkg.sv
frb_buffer.sv
pio_regs.sv
ring_sched.sv
f2c_ring.sv
pcie_top.sv
tb_pcie_top.sv

// File: pcie_top.sv
`timescale 1ns/1ps

module pcie_top
    import pcie_rb_pkg::*;
#(
    parameter int NB_CORES = 4,
    parameter int RB_AWIDTH = 16,
    parameter int PCIE_ADDR_WIDTH = 16,
    parameter int MAX_PDU_FLITS = 8,
    parameter int PEND_DEPTH = 4,
    localparam int BUF_AW = $clog2(PEND_DEPTH * MAX_PDU_FLITS),
    localparam int SIZE_W = $clog2(MAX_PDU_FLITS + 1)
) (
    input  logic                       pcie_clk,
    input  logic                       pcie_reset_n,
    input  logic                       pcie_wrdm_desc_ready,
    output logic                       pcie_wrdm_desc_valid,
    output wrdm_desc_t                 pcie_wrdm_desc_data,
    input  logic [PCIE_ADDR_WIDTH-1:0] pcie_address_0,
    input  logic                       pcie_read_0,
    input  logic                       pcie_write_0,
    input  flit_t                      pcie_writedata_0,
    input  logic [63:0]                pcie_byteenable_0,
    output logic                       pcie_readdatavalid_0,
    output flit_t                      pcie_readdata_0,
    input  flit_t                      pcie_rb_wr_data,
    input  logic [BUF_AW-1:0]          pcie_rb_wr_addr,
    input  logic                       pcie_rb_wr_en,
    output logic [BUF_AW-1:0]          pcie_rb_wr_base_addr,
    output logic                       pcie_rb_wr_base_addr_valid,
    output logic                       pcie_rb_almost_full,
    input  logic                       pcie_rb_update_valid,
    input  logic [SIZE_W-1:0]          pcie_rb_update_size,
    output logic                       disable_pcie
);

    logic [NB_CORES-1:0][RB_AWIDTH-1:0] tails;
    logic [NB_CORES-1:0][RB_AWIDTH-1:0] heads;
    logic [NB_CORES-1:0][63:0]          kmem_addrs;
    ctrl_reg_t                          ctrl;
    ring_sel_t                          sel;
    logic                               buf_read;
    logic [BUF_AW-1:0]                  buf_line;
    flit_t                              buf_rdata;
    logic                               dma_done;
    logic [RB_AWIDTH-1:0]               new_tail;

    assign disable_pcie = ctrl.disabled;

    frb_buffer #(
        .MAX_PDU_FLITS (MAX_PDU_FLITS),
        .PEND_DEPTH    (PEND_DEPTH)
    ) i_frb_buffer (
        .pcie_clk     (pcie_clk),
        .pcie_reset_n (pcie_reset_n),
        .wr_en        (pcie_rb_wr_en),
        .wr_line      (pcie_rb_wr_addr),
        .wr_data      (pcie_rb_wr_data),
        .rd_en        (buf_read),
        .rd_line      (buf_line),
        .rd_data      (buf_rdata)
    );

    pio_regs #(
        .NB_CORES        (NB_CORES),
        .RB_AWIDTH       (RB_AWIDTH),
        .PCIE_ADDR_WIDTH (PCIE_ADDR_WIDTH),
        .MAX_PDU_FLITS   (MAX_PDU_FLITS),
        .PEND_DEPTH      (PEND_DEPTH)
    ) i_pio_regs (
        .pcie_clk             (pcie_clk),
        .pcie_reset_n         (pcie_reset_n),
        .pcie_address_0       (pcie_address_0),
        .pcie_read_0          (pcie_read_0),
        .pcie_write_0         (pcie_write_0),
        .pcie_writedata_0     (pcie_writedata_0),
        .pcie_byteenable_0    (pcie_byteenable_0),
        .pcie_readdatavalid_0 (pcie_readdatavalid_0),
        .pcie_readdata_0      (pcie_readdata_0),
        .tails                (tails),
        .heads                (heads),
        .kmem_addrs           (kmem_addrs),
        .ctrl                 (ctrl),
        .buf_read             (buf_read),
        .buf_line             (buf_line),
        .buf_rdata            (buf_rdata)
    );

    ring_sched #(
        .NB_CORES  (NB_CORES),
        .RB_AWIDTH (RB_AWIDTH)
    ) i_ring_sched (
        .pcie_clk     (pcie_clk),
        .pcie_reset_n (pcie_reset_n),
        .ctrl         (ctrl),
        .heads        (heads),
        .kmem_addrs   (kmem_addrs),
        .dma_done     (dma_done),
        .new_tail     (new_tail),
        .tails        (tails),
        .sel          (sel)
    );

    f2c_ring #(
        .RB_AWIDTH     (RB_AWIDTH),
        .MAX_PDU_FLITS (MAX_PDU_FLITS),
        .PEND_DEPTH    (PEND_DEPTH)
    ) i_f2c_ring (
        .pcie_clk        (pcie_clk),
        .pcie_reset_n    (pcie_reset_n),
        .ctrl            (ctrl),
        .sel             (sel),
        .update_valid    (pcie_rb_update_valid),
        .update_size     (pcie_rb_update_size),
        .base_addr       (pcie_rb_wr_base_addr),
        .base_addr_valid (pcie_rb_wr_base_addr_valid),
        .almost_full     (pcie_rb_almost_full),
        .wrdm_desc_valid (pcie_wrdm_desc_valid),
        .wrdm_desc_data  (pcie_wrdm_desc_data),
        .wrdm_desc_ready (pcie_wrdm_desc_ready),
        .dma_done        (dma_done),
        .new_tail        (new_tail)
    );

endmodule

// File: pio_regs.sv
`timescale 1ns/1ps

module pio_regs
    import pcie_rb_pkg::*;
#(
    parameter int NB_CORES = 4,
    parameter int RB_AWIDTH = 16,
    parameter int PCIE_ADDR_WIDTH = 16,
    parameter int MAX_PDU_FLITS = 8,
    parameter int PEND_DEPTH = 4,
    localparam int BUF_AW = $clog2(PEND_DEPTH * MAX_PDU_FLITS)
) (
    input  logic                              pcie_clk,
    input  logic                              pcie_reset_n,
    input  logic [PCIE_ADDR_WIDTH-1:0]        pcie_address_0,
    input  logic                              pcie_read_0,
    input  logic                              pcie_write_0,
    input  flit_t                             pcie_writedata_0,
    input  logic [63:0]                       pcie_byteenable_0,
    output logic                              pcie_readdatavalid_0,
    output flit_t                             pcie_readdata_0,
    input  logic [NB_CORES-1:0][RB_AWIDTH-1:0] tails,
    output logic [NB_CORES-1:0][RB_AWIDTH-1:0] heads,
    output logic [NB_CORES-1:0][63:0]         kmem_addrs,
    output ctrl_reg_t                         ctrl,
    output logic                              buf_read,
    output logic [BUF_AW-1:0]                 buf_line,
    input  flit_t                             buf_rdata
);

    localparam int PG_W = PCIE_ADDR_WIDTH - PAGE_BITS;
    localparam int CORE_W = (NB_CORES > 1) ? $clog2(NB_CORES) : 1;
    localparam int PAGE_DW = REGS_PER_PAGE * 32;
    localparam logic [PCIE_ADDR_WIDTH-1:0] BUF_BASE =
        PCIE_ADDR_WIDTH'((NB_CORES + 1) << PAGE_BITS);

    // words 1..3 of every core page; word 0 is the tail
    logic [31:0]                core_words [NB_CORES][1:REGS_PER_PAGE-1];
    logic [PG_W-1:0]            page_idx;
    logic [CORE_W-1:0]          core_sel;
    logic                       is_core;
    logic                       is_ctrl;
    logic                       is_buf;
    logic [PCIE_ADDR_WIDTH-1:0] buf_off;
    logic [PAGE_DW-1:0]         page_data;
    logic [PAGE_DW-1:0]         page_data_r1;
    logic [PAGE_DW-1:0]         page_data_r2;
    logic                       read_r1;
    logic                       reg_region_r1;
    logic                       reg_region_r2;

    assign page_idx = pcie_address_0[PCIE_ADDR_WIDTH-1:PAGE_BITS];
    assign core_sel = page_idx[CORE_W-1:0];
    assign is_core  = page_idx < PG_W'(NB_CORES);
    assign is_ctrl  = page_idx == PG_W'(NB_CORES);
    assign is_buf   = page_idx > PG_W'(NB_CORES);

    // buffer region, one line per 64-byte flit
    assign buf_off  = pcie_address_0 - BUF_BASE;
    assign buf_line = buf_off[FLIT_BYTE_BITS +: BUF_AW];
    assign buf_read = pcie_read_0 & is_buf;

    // host writes, whole dwords only
    always_ff @(posedge pcie_clk) begin
        if (!pcie_reset_n) begin
            for (int c = 0; c < NB_CORES; c++) begin
                for (int w = 1; w < REGS_PER_PAGE; w++) begin
                    core_words[c][w] <= '0;
                end
            end
            ctrl <= '{total_core: 5'd1, rb_size: '0, disabled: 1'b1};
        end else if (pcie_write_0) begin
            if (is_core) begin
                // word 0 is skipped, the tail belongs to the scheduler
                for (int w = 1; w < REGS_PER_PAGE; w++) begin
                    if (&pcie_byteenable_0[w*4 +: 4]) begin
                        core_words[core_sel][w] <= pcie_writedata_0[w*32 +: 32];
                    end
                end
            end else if (is_ctrl && (&pcie_byteenable_0[3:0])) begin
                ctrl <= ctrl_reg_t'(pcie_writedata_0[31:0]);
            end
        end
    end

    always_comb begin
        for (int c = 0; c < NB_CORES; c++) begin
            heads[c]      = core_words[c][1][RB_AWIDTH-1:0];
            kmem_addrs[c] = {core_words[c][3], core_words[c][2]};
        end
    end

    // addressed page as seen at request time
    always_comb begin
        page_data = '0;
        if (is_core) begin
            page_data[31:0] = 32'(tails[core_sel]);
            for (int w = 1; w < REGS_PER_PAGE; w++) begin
                page_data[w*32 +: 32] = core_words[core_sel][w];
            end
        end else if (is_ctrl) begin
            page_data[31:0] = ctrl;
        end
    end

    always_ff @(posedge pcie_clk) begin
        if (!pcie_reset_n) begin
            read_r1              <= 1'b0;
            pcie_readdatavalid_0 <= 1'b0;
        end else begin
            read_r1              <= pcie_read_0;
            pcie_readdatavalid_0 <= read_r1;
        end
    end

    // register data follows the same two stages as the buffer read
    always_ff @(posedge pcie_clk) begin
        reg_region_r1 <= !is_buf;
        reg_region_r2 <= reg_region_r1;
        page_data_r1  <= page_data;
        page_data_r2  <= page_data_r1;
    end

    assign pcie_readdata_0 = reg_region_r2 ? {{(512-PAGE_DW){1'b0}}, page_data_r2} : buf_rdata;

endmodule

// File: ring_sched.sv
`timescale 1ns/1ps

module ring_sched
    import pcie_rb_pkg::*;
#(
    parameter int NB_CORES = 4,
    parameter int RB_AWIDTH = 16
) (
    input  logic                               pcie_clk,
    input  logic                               pcie_reset_n,
    input  ctrl_reg_t                          ctrl,
    input  logic [NB_CORES-1:0][RB_AWIDTH-1:0] heads,
    input  logic [NB_CORES-1:0][63:0]          kmem_addrs,
    input  logic                               dma_done,
    input  logic [RB_AWIDTH-1:0]               new_tail,
    output logic [NB_CORES-1:0][RB_AWIDTH-1:0] tails,
    output ring_sel_t                          sel
);

    localparam int CORE_W = (NB_CORES > 1) ? $clog2(NB_CORES) : 1;

    logic [CORE_W-1:0] core_id;
    logic              last_core;

    // wrap at the host's core count, never past the last page
    assign last_core = (5'(core_id) == ctrl.total_core - 5'd1) ||
                       (32'(core_id) == NB_CORES - 1);

    always_ff @(posedge pcie_clk) begin
        if (!pcie_reset_n) begin
            tails   <= '0;
            core_id <= '0;
        end else if (dma_done) begin
            tails[core_id] <= new_tail;
            if (last_core) begin
                core_id <= '0;
            end else begin
                core_id <= core_id + 1'b1;
            end
        end
    end

    // active ring, one cycle behind core_id
    always_ff @(posedge pcie_clk) begin
        sel.head      <= 32'(heads[core_id]);
        sel.tail      <= 32'(tails[core_id]);
        sel.kmem_addr <= kmem_addrs[core_id];
    end

    a_core_in_range: assert property (@(posedge pcie_clk) disable iff (!pcie_reset_n)
        !ctrl.disabled |-> 5'(core_id) < ctrl.total_core);

endmodule

// File: tb_pcie_top.sv
`timescale 1ns/1ps

module tb_pcie_top
    import pcie_rb_pkg::*;
();

    localparam int NB_CORES = 4;
    localparam int PEND_DEPTH = 4;
    localparam int MAX_PDU_FLITS = 8;
    localparam int RB_SIZE = 9;
    localparam int CYCLE_LIMIT = 4000;
    localparam logic [15:0] CTRL_ADDR = 16'(NB_CORES << PAGE_BITS);
    localparam logic [15:0] BUF_ADDR = 16'((NB_CORES + 1) << PAGE_BITS);

    logic        pcie_clk = 1'b0;
    logic        pcie_reset_n;
    logic        pcie_wrdm_desc_ready;
    logic        pcie_wrdm_desc_valid;
    wrdm_desc_t  pcie_wrdm_desc_data;
    logic [15:0] pcie_address_0;
    logic        pcie_read_0;
    logic        pcie_write_0;
    flit_t       pcie_writedata_0;
    logic [63:0] pcie_byteenable_0;
    logic        pcie_readdatavalid_0;
    flit_t       pcie_readdata_0;
    flit_t       pcie_rb_wr_data;
    logic [4:0]  pcie_rb_wr_addr;
    logic        pcie_rb_wr_en;
    logic [4:0]  pcie_rb_wr_base_addr;
    logic        pcie_rb_wr_base_addr_valid;
    logic        pcie_rb_almost_full;
    logic        pcie_rb_update_valid;
    logic [3:0]  pcie_rb_update_size;
    logic        disable_pcie;

    // host-visible model: page words, word 0 is the tail
    logic [31:0] m_word [NB_CORES][4];
    int          m_core;
    int          m_total;
    int          m_slot;
    logic [7:0]  m_id;
    int          exp_base_q[$];
    int          exp_size_q[$];
    logic [31:0] lcg_state = 32'h3f5d;
    int          cycle_count = 0;

    pcie_top i_pcie_top (.*);

    always #50 pcie_clk = ~pcie_clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic flit_t rand_flit();
        flit_t f;
        for (int w = 0; w < 16; w++) begin
            f[w*32 +: 32] = lcg_next();
        end
        return f;
    endfunction

    function automatic logic [3:0] rand_size();
        logic [31:0] r;
        r = lcg_next();
        return 4'(r[18:16]) + 4'd1;
    endfunction

    function automatic logic [31:0] ctrl_word(input int total, input int rb, input logic dis);
        ctrl_reg_t c;
        c.total_core = 5'(total);
        c.rb_size    = 26'(rb);
        c.disabled   = dis;
        return c;
    endfunction

    function automatic flit_t page_flit(input logic [31:0] tail_try, input logic [31:0] head,
                                        input logic [31:0] klo, input logic [31:0] khi);
        flit_t f;
        f = '0;
        f[127:0] = {khi, klo, head, tail_try};
        return f;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    // hang guard
    always @(posedge pcie_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == CYCLE_LIMIT) begin
            abort_run("run exceeded the cycle limit, the DUT stopped responding");
        end
    end

    task automatic compare_flit(input string name, input flit_t exp, input flit_t act);
        if (act !== exp) begin
            abort_run($sformatf("[FAIL] %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic compare_desc(input string name, input wrdm_desc_t exp, input wrdm_desc_t act);
        if (act !== exp) begin
            abort_run($sformatf("[FAIL] %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic compare_word(input string name, input logic [31:0] exp,
                                input logic [31:0] act);
        if (act !== exp) begin
            abort_run($sformatf("[FAIL] %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic pio_write(input logic [15:0] addr, input flit_t wd, input logic [63:0] be);
        @(posedge pcie_clk);
        pcie_address_0    <= addr;
        pcie_writedata_0  <= wd;
        pcie_byteenable_0 <= be;
        pcie_write_0      <= 1'b1;
        @(posedge pcie_clk);
        pcie_write_0      <= 1'b0;
    endtask

    // data must show up on the second edge after the request, not earlier
    task automatic pio_read(input logic [15:0] addr, output flit_t data);
        @(posedge pcie_clk);
        pcie_address_0 <= addr;
        pcie_read_0    <= 1'b1;
        @(posedge pcie_clk);
        pcie_read_0    <= 1'b0;
        @(negedge pcie_clk);
        compare_word("readdatavalid early", 32'd0, 32'(pcie_readdatavalid_0));
        @(negedge pcie_clk);
        compare_word("readdatavalid latency", 32'd1, 32'(pcie_readdatavalid_0));
        data = pcie_readdata_0;
    endtask

    task automatic host_write_page(input int core, input flit_t wd, input logic [63:0] be);
        pio_write(16'(core << PAGE_BITS), wd, be);
        for (int w = 1; w < 4; w++) begin
            if (&be[w*4 +: 4]) begin
                m_word[core][w] = wd[w*32 +: 32];
            end
        end
    endtask

    task automatic set_head(input int core, input int head);
        host_write_page(core, page_flit(32'd0, 32'(head), 32'd0, 32'd0), 64'h00f0);
    endtask

    task automatic write_ctrl(input int total, input int rb, input logic dis);
        flit_t wd;
        wd = '0;
        wd[31:0] = ctrl_word(total, rb, dis);
        pio_write(CTRL_ADDR, wd, 64'h000f);
        m_total = total;
    endtask

    task automatic check_page(input string name, input int core);
        flit_t got;
        flit_t exp;
        pio_read(16'(core << PAGE_BITS), got);
        exp = '0;
        for (int w = 0; w < 4; w++) begin
            exp[w*32 +: 32] = m_word[core][w];
        end
        compare_flit(name, exp, got);
    endtask

    task automatic write_line(input int line, input flit_t data);
        @(posedge pcie_clk);
        pcie_rb_wr_addr <= 5'(line);
        pcie_rb_wr_data <= data;
        pcie_rb_wr_en   <= 1'b1;
        @(posedge pcie_clk);
        pcie_rb_wr_en   <= 1'b0;
    endtask

    task automatic commit_pdu(input logic [3:0] size);
        @(negedge pcie_clk);
        compare_word("base_addr_valid before commit", 32'd1, 32'(pcie_rb_wr_base_addr_valid));
        compare_word("slot base", 32'(m_slot * MAX_PDU_FLITS), 32'(pcie_rb_wr_base_addr));
        @(posedge pcie_clk);
        pcie_rb_update_valid <= 1'b1;
        pcie_rb_update_size  <= size;
        @(posedge pcie_clk);
        pcie_rb_update_valid <= 1'b0;
        exp_base_q.push_back(m_slot * MAX_PDU_FLITS);
        exp_size_q.push_back(int'(size));
        m_slot = (m_slot + 1) % PEND_DEPTH;
    endtask

    function automatic wrdm_desc_t expected_desc();
        wrdm_desc_t d;
        d.dst_addr = {m_word[m_core][3], m_word[m_core][2]} + 64'(m_word[m_core][0]) * 64;
        d.src_addr = 64'(exp_base_q[0]) * 64;
        d.desc_id  = m_id;
        d.dw_count = 18'(exp_size_q[0] * 16);
        d.rsvd     = '0;
        return d;
    endfunction

    task automatic check_desc(input string name);
        @(negedge pcie_clk);
        while (!pcie_wrdm_desc_valid) begin
            @(negedge pcie_clk);
        end
        compare_desc(name, expected_desc(), pcie_wrdm_desc_data);
    endtask

    // one ready pulse, then the ring rule on the model
    task automatic accept_desc();
        int t;
        @(posedge pcie_clk);
        pcie_wrdm_desc_ready <= 1'b1;
        @(posedge pcie_clk);
        pcie_wrdm_desc_ready <= 1'b0;
        t = int'(m_word[m_core][0]) + exp_size_q.pop_front();
        if (t >= RB_SIZE) begin
            t = t - RB_SIZE;
        end
        void'(exp_base_q.pop_front());
        m_word[m_core][0] = 32'(t);
        m_core = (m_core + 1) % m_total;
        m_id++;
    endtask

    task automatic test_reset_state();
        flit_t got;
        flit_t exp;
        for (int c = 0; c < NB_CORES; c++) begin
            for (int w = 0; w < 4; w++) begin
                m_word[c][w] = '0;
            end
        end
        @(negedge pcie_clk);
        compare_word("reset desc_valid", 32'd0, 32'(pcie_wrdm_desc_valid));
        compare_word("reset readdatavalid", 32'd0, 32'(pcie_readdatavalid_0));
        compare_word("reset base_addr_valid", 32'd0, 32'(pcie_rb_wr_base_addr_valid));
        compare_word("reset disable_pcie", 32'd1, 32'(disable_pcie));
        pio_read(CTRL_ADDR, got);
        exp = '0;
        exp[31:0] = ctrl_word(1, 0, 1'b1);
        compare_flit("reset control page", exp, got);
    endtask

    task automatic test_register_access();
        logic [63:0] be;
        for (int c = 0; c < NB_CORES; c++) begin
            be = 64'hffff;
            // partial dwords on word 3 and word 1
            if (c == 2) begin
                be = 64'h7fff;
            end
            if (c == 3) begin
                be = 64'hff3f;
            end
            host_write_page(c, rand_flit(), be);
        end
        for (int c = 0; c < NB_CORES; c++) begin
            check_page("register access", c);
        end
    endtask

    task automatic test_buffer_readback();
        flit_t lines [8];
        flit_t got;
        for (int i = 0; i < 8; i++) begin
            lines[i] = rand_flit();
            write_line((i * 7) % 32, lines[i]);
        end
        for (int i = 0; i < 8; i++) begin
            pio_read(BUF_ADDR + 16'(((i * 7) % 32) * 64), got);
            compare_flit("buffer readback", lines[i], got);
        end
    endtask

    task automatic test_descriptors();
        int served;
        for (int c = 0; c < 3; c++) begin
            host_write_page(c, page_flit(32'd0, 32'd0, lcg_next() & 32'hffff_f000,
                                         lcg_next()), 64'hffff);
        end
        write_ctrl(3, RB_SIZE, 1'b0);
        // cores 0, 1, 2 then 0 again
        for (int n = 0; n < 4; n++) begin
            served = m_core;
            set_head(m_core, int'(m_word[m_core][0]));
            // a full-size pdu on the second pass makes core 0 wrap
            commit_pdu((n == 3) ? 4'd8 : rand_size());
            check_desc("descriptor round robin");
            accept_desc();
            check_page("tail advance", served);
        end
    endtask

    task automatic test_backpressure();
        wrdm_desc_t held;
        int         core;
        set_head(m_core, int'(m_word[m_core][0]));
        commit_pdu(rand_size());
        check_desc("backpressure descriptor");
        held = pcie_wrdm_desc_data;
        repeat (5) begin
            @(negedge pcie_clk);
            compare_word("backpressure valid", 32'd1, 32'(pcie_wrdm_desc_valid));
            compare_desc("backpressure hold", held, pcie_wrdm_desc_data);
        end
        accept_desc();
        // one free flit left for the next core
        core = m_core;
        set_head(core, (int'(m_word[core][0]) + 2) % RB_SIZE);
        commit_pdu(4'd4);
        repeat (20) begin
            @(negedge pcie_clk);
            compare_word("ring full no descriptor", 32'd0, 32'(pcie_wrdm_desc_valid));
        end
        set_head(core, (int'(m_word[core][0]) + 6) % RB_SIZE);
        check_desc("ring full release");
        accept_desc();
    endtask

    task automatic test_flow_control();
        set_head(m_core, int'(m_word[m_core][0]));
        set_head((m_core + 1) % m_total, int'(m_word[(m_core + 1) % m_total][0]));
        commit_pdu(rand_size());
        commit_pdu(rand_size());
        @(negedge pcie_clk);
        compare_word("almost_full low", 32'd0, 32'(pcie_rb_almost_full));
        commit_pdu(rand_size());
        @(negedge pcie_clk);
        compare_word("almost_full high", 32'd1, 32'(pcie_rb_almost_full));
        commit_pdu(rand_size());
        @(negedge pcie_clk);
        compare_word("queue full", 32'd0, 32'(pcie_rb_wr_base_addr_valid));
        check_desc("flow first descriptor");
        accept_desc();
        @(negedge pcie_clk);
        compare_word("queue drained one", 32'd1, 32'(pcie_rb_wr_base_addr_valid));
        check_desc("flow second descriptor");
        write_ctrl(3, RB_SIZE, 1'b1);
        @(negedge pcie_clk);
        compare_word("disabled base_addr_valid", 32'd0, 32'(pcie_rb_wr_base_addr_valid));
        compare_word("disabled flag", 32'd1, 32'(disable_pcie));
        accept_desc();
        repeat (20) begin
            @(negedge pcie_clk);
            compare_word("disabled no descriptor", 32'd0, 32'(pcie_wrdm_desc_valid));
        end
    endtask

    initial begin
        pcie_reset_n         = 1'b0;
        pcie_wrdm_desc_ready = 1'b0;
        pcie_address_0       = '0;
        pcie_read_0          = 1'b0;
        pcie_write_0         = 1'b0;
        pcie_writedata_0     = '0;
        pcie_byteenable_0    = '0;
        pcie_rb_wr_data      = '0;
        pcie_rb_wr_addr      = '0;
        pcie_rb_wr_en        = 1'b0;
        pcie_rb_update_valid = 1'b0;
        pcie_rb_update_size  = '0;
        m_core  = 0;
        m_total = 1;
        m_slot  = 0;
        m_id    = '0;
        repeat (8) @(posedge pcie_clk);
        pcie_reset_n <= 1'b1;
        test_reset_state();
        test_register_access();
        test_buffer_readback();
        test_descriptors();
        test_backpressure();
        test_flow_control();
        $display("RESULT: PASS");
        $finish;
    end

endmodule
